// File: design/cpu_pkg.sv
package cpu_pkg;

    // ******************************
    // instruction opcodes, bits 15..11
    // ******************************
    typedef enum logic [4:0] {
        OPC_NOP   = 5'b00001,
        OPC_B     = 5'b00010,
        OPC_BEQZ  = 5'b00100,
        OPC_ADDIU = 5'b01001,
        OPC_LI    = 5'b01101,
        OPC_LW    = 5'b10011,
        OPC_SW    = 5'b11011,
        OPC_RRR   = 5'b11100,
        OPC_LOGIC = 5'b11101
    } opcode_e;

    // alu functions
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_PASS_B
    } alu_op_e;

    // register writeback source
    typedef enum logic {
        WB_ALU,
        WB_MEM
    } wb_src_e;

    // operand source in execute
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EX_MEM,
        FWD_MEM_WB
    } fwd_src_e;

endpackage

// File: design/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_top (
    input  logic                   clk_50MHz,
    input  logic                   rst,
    output logic [`CPU_DATA_W-1:0] imem_addr,
    input  logic [`CPU_DATA_W-1:0] imem_inst,
    output logic [`CPU_DATA_W-1:0] dmem_addr,
    output logic [`CPU_DATA_W-1:0] dmem_wdata,
    output logic                   dmem_en,
    output logic                   dmem_we,
    input  logic [`CPU_DATA_W-1:0] dmem_rdata
);

    // fetch to decode
    logic [`CPU_DATA_W-1:0]     inst;
    logic [`CPU_DATA_W-1:0]     pc_next;
    logic                       stall;
    logic                       branch_taken;
    logic [`CPU_DATA_W-1:0]     branch_target;

    // register file ports
    logic [`CPU_REG_ADDR_W-1:0] rd_addr_a;
    logic [`CPU_REG_ADDR_W-1:0] rd_addr_b;
    logic [`CPU_DATA_W-1:0]     rd_data_a;
    logic [`CPU_DATA_W-1:0]     rd_data_b;
    logic                       wr_en;
    logic [`CPU_REG_ADDR_W-1:0] wr_addr;
    logic [`CPU_DATA_W-1:0]     wr_data;

    // decode/execute register
    cpu_pkg::alu_op_e           ex_alu_op;
    cpu_pkg::wb_src_e           ex_wb_src;
    logic                       ex_reg_wr;
    logic                       ex_mem_en;
    logic                       ex_mem_we;
    logic                       ex_is_branch;
    logic                       ex_is_cond;
    logic                       ex_use_imm;
    logic [`CPU_REG_ADDR_W-1:0] ex_dest;
    logic [`CPU_REG_ADDR_W-1:0] ex_src_a;
    logic [`CPU_REG_ADDR_W-1:0] ex_src_b;
    logic [`CPU_DATA_W-1:0]     ex_op_a;
    logic [`CPU_DATA_W-1:0]     ex_op_b;
    logic [`CPU_DATA_W-1:0]     ex_imm;
    logic [`CPU_DATA_W-1:0]     ex_pc_next;

    // forwarding and memory stage
    cpu_pkg::fwd_src_e          fwd_a;
    cpu_pkg::fwd_src_e          fwd_b;
    logic [`CPU_REG_ADDR_W-1:0] mem_dest;
    logic                       mem_reg_wr;
    cpu_pkg::wb_src_e           mem_wb_src;
    logic [`CPU_DATA_W-1:0]     mem_alu_result;

    // ******************************
    // pipeline stages
    // ******************************
    fetch_unit u_fetch (.*);

    decode_unit u_decode (
        .flush(branch_taken),
        .*
    );

    reg_file u_regs (.*);

    hazard_unit u_hazard (
        .wb_dest  (wr_addr),
        .wb_reg_wr(wr_en),
        .*
    );

    execute_unit u_execute (
        .wb_data(wr_data),
        .*
    );

    writeback_unit u_writeback (.*);

endmodule

// File: design/decode_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module decode_unit (
    input  logic                       clk_50MHz,
    input  logic                       rst,
    input  logic                       stall,
    input  logic                       flush,
    input  logic [`CPU_DATA_W-1:0]     inst,
    input  logic [`CPU_DATA_W-1:0]     pc_next,
    input  logic [`CPU_DATA_W-1:0]     rd_data_a,
    input  logic [`CPU_DATA_W-1:0]     rd_data_b,
    output logic [`CPU_REG_ADDR_W-1:0] rd_addr_a,
    output logic [`CPU_REG_ADDR_W-1:0] rd_addr_b,
    output cpu_pkg::alu_op_e           ex_alu_op,
    output cpu_pkg::wb_src_e           ex_wb_src,
    output logic                       ex_reg_wr,
    output logic                       ex_mem_en,
    output logic                       ex_mem_we,
    output logic                       ex_is_branch,
    output logic                       ex_is_cond,
    output logic [`CPU_REG_ADDR_W-1:0] ex_dest,
    output logic [`CPU_REG_ADDR_W-1:0] ex_src_a,
    output logic [`CPU_REG_ADDR_W-1:0] ex_src_b,
    output logic [`CPU_DATA_W-1:0]     ex_op_a,
    output logic [`CPU_DATA_W-1:0]     ex_op_b,
    output logic [`CPU_DATA_W-1:0]     ex_imm,
    output logic                       ex_use_imm,
    output logic [`CPU_DATA_W-1:0]     ex_pc_next
);

    cpu_pkg::opcode_e           opc;
    cpu_pkg::alu_op_e           alu_op;
    cpu_pkg::wb_src_e           wb_src;
    logic [`CPU_REG_ADDR_W-1:0] rx;
    logic [`CPU_REG_ADDR_W-1:0] ry;
    logic [`CPU_REG_ADDR_W-1:0] rz;
    logic [`CPU_REG_ADDR_W-1:0] dest;
    logic [`CPU_DATA_W-1:0]     imm;
    logic                       reg_wr;
    logic                       mem_en;
    logic                       mem_we;
    logic                       is_branch;
    logic                       is_cond;
    logic                       use_imm;
    logic                       bubble;

    assign opc       = cpu_pkg::opcode_e'(inst[`CPU_OPC_HI:`CPU_OPC_LO]);
    assign rx        = inst[`CPU_RX_HI:`CPU_RX_LO];
    assign ry        = inst[`CPU_RY_HI:`CPU_RY_LO];
    assign rz        = inst[`CPU_RZ_HI:`CPU_RZ_LO];
    assign rd_addr_a = rx;
    assign rd_addr_b = ry;
    assign bubble    = stall | flush;

    // ******************************
    // control decode
    // ******************************
    always_comb begin
        alu_op    = cpu_pkg::ALU_ADD;
        wb_src    = cpu_pkg::WB_ALU;
        reg_wr    = 1'b0;
        mem_en    = 1'b0;
        mem_we    = 1'b0;
        is_branch = 1'b0;
        is_cond   = 1'b0;
        use_imm   = 1'b0;
        dest      = rx;
        imm       = {{(`CPU_DATA_W-8){inst[7]}}, inst[7:0]};
        case (opc)
            cpu_pkg::OPC_ADDIU: begin
                reg_wr  = 1'b1;
                use_imm = 1'b1;
            end
            cpu_pkg::OPC_LI: begin
                alu_op  = cpu_pkg::ALU_PASS_B;
                reg_wr  = 1'b1;
                use_imm = 1'b1;
                imm     = {{(`CPU_DATA_W-8){1'b0}}, inst[7:0]};
            end
            cpu_pkg::OPC_RRR: begin
                // 01 add, 11 sub, others do nothing
                alu_op = inst[1] ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
                reg_wr = inst[0];
                dest   = rz;
            end
            cpu_pkg::OPC_LOGIC: begin
                alu_op = inst[0] ? cpu_pkg::ALU_OR : cpu_pkg::ALU_AND;
                reg_wr = (inst[4:1] == 4'b0110);
            end
            cpu_pkg::OPC_LW, cpu_pkg::OPC_SW: begin
                // rx + imm5 address
                mem_en  = 1'b1;
                mem_we  = (opc == cpu_pkg::OPC_SW);
                reg_wr  = (opc == cpu_pkg::OPC_LW);
                wb_src  = cpu_pkg::WB_MEM;
                use_imm = 1'b1;
                dest    = ry;
                imm     = {{(`CPU_DATA_W-5){inst[4]}}, inst[4:0]};
            end
            cpu_pkg::OPC_BEQZ: begin
                is_branch = 1'b1;
                is_cond   = 1'b1;
            end
            cpu_pkg::OPC_B: begin
                is_branch = 1'b1;
                imm       = {{(`CPU_DATA_W-11){inst[10]}}, inst[10:0]};
            end
            default: begin
                // NOP and unknown opcodes
                reg_wr = 1'b0;
            end
        endcase
    end

    // decode/execute register, a bubble on stall or flush
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            ex_reg_wr    <= 1'b0;
            ex_mem_en    <= 1'b0;
            ex_mem_we    <= 1'b0;
            ex_is_branch <= 1'b0;
        end else begin
            ex_reg_wr    <= reg_wr & ~bubble;
            ex_mem_en    <= mem_en & ~bubble;
            ex_mem_we    <= mem_we & ~bubble;
            ex_is_branch <= is_branch & ~bubble;
        end
    end

    always_ff @(posedge clk_50MHz) begin
        ex_alu_op  <= alu_op;
        ex_wb_src  <= wb_src;
        ex_is_cond <= is_cond;
        ex_use_imm <= use_imm;
        ex_dest    <= dest;
        ex_src_a   <= rx;
        ex_src_b   <= ry;
        ex_op_a    <= rd_data_a;
        ex_op_b    <= rd_data_b;
        ex_imm     <= imm;
        ex_pc_next <= pc_next;
    end

endmodule

// File: design/execute_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module execute_unit (
    input  logic                       clk_50MHz,
    input  logic                       rst,
    input  cpu_pkg::alu_op_e           ex_alu_op,
    input  cpu_pkg::wb_src_e           ex_wb_src,
    input  logic                       ex_reg_wr,
    input  logic                       ex_mem_en,
    input  logic                       ex_mem_we,
    input  logic                       ex_is_branch,
    input  logic                       ex_is_cond,
    input  logic [`CPU_REG_ADDR_W-1:0] ex_dest,
    input  logic [`CPU_DATA_W-1:0]     ex_op_a,
    input  logic [`CPU_DATA_W-1:0]     ex_op_b,
    input  logic [`CPU_DATA_W-1:0]     ex_imm,
    input  logic                       ex_use_imm,
    input  logic [`CPU_DATA_W-1:0]     ex_pc_next,
    input  cpu_pkg::fwd_src_e          fwd_a,
    input  cpu_pkg::fwd_src_e          fwd_b,
    input  logic [`CPU_DATA_W-1:0]     wb_data,
    output logic                       branch_taken,
    output logic [`CPU_DATA_W-1:0]     branch_target,
    output logic [`CPU_DATA_W-1:0]     dmem_addr,
    output logic [`CPU_DATA_W-1:0]     dmem_wdata,
    output logic                       dmem_en,
    output logic                       dmem_we,
    output logic [`CPU_REG_ADDR_W-1:0] mem_dest,
    output logic                       mem_reg_wr,
    output cpu_pkg::wb_src_e           mem_wb_src,
    output logic [`CPU_DATA_W-1:0]     mem_alu_result
);

    logic [`CPU_DATA_W-1:0] op_a;
    logic [`CPU_DATA_W-1:0] op_b;
    logic [`CPU_DATA_W-1:0] alu_b;
    logic [`CPU_DATA_W-1:0] alu_result;

    function automatic logic [`CPU_DATA_W-1:0] fwd_mux(
        input cpu_pkg::fwd_src_e      sel,
        input logic [`CPU_DATA_W-1:0] reg_val,
        input logic [`CPU_DATA_W-1:0] mem_val,
        input logic [`CPU_DATA_W-1:0] wb_val
    );
        case (sel)
            cpu_pkg::FWD_EX_MEM: return mem_val;
            cpu_pkg::FWD_MEM_WB: return wb_val;
            default:             return reg_val;
        endcase
    endfunction

    assign op_a  = fwd_mux(fwd_a, ex_op_a, mem_alu_result, wb_data);
    assign op_b  = fwd_mux(fwd_b, ex_op_b, mem_alu_result, wb_data);
    assign alu_b = ex_use_imm ? ex_imm : op_b;

    always_comb begin
        case (ex_alu_op)
            cpu_pkg::ALU_ADD: alu_result = op_a + alu_b;
            cpu_pkg::ALU_SUB: alu_result = op_a - alu_b;
            cpu_pkg::ALU_AND: alu_result = op_a & alu_b;
            cpu_pkg::ALU_OR:  alu_result = op_a | alu_b;
            default:          alu_result = alu_b;
        endcase
    end

    // beqz tests the forwarded rx
    assign branch_taken  = ex_is_branch && (!ex_is_cond || op_a == '0);
    assign branch_target = ex_pc_next + ex_imm;

    // ******************************
    // execute/memory register
    // ******************************
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            dmem_en    <= 1'b0;
            dmem_we    <= 1'b0;
            mem_reg_wr <= 1'b0;
        end else begin
            dmem_en    <= ex_mem_en;
            dmem_we    <= ex_mem_we;
            mem_reg_wr <= ex_reg_wr;
        end
    end

    always_ff @(posedge clk_50MHz) begin
        mem_dest       <= ex_dest;
        mem_wb_src     <= ex_wb_src;
        mem_alu_result <= alu_result;
        dmem_wdata     <= op_b;
    end

    assign dmem_addr = mem_alu_result;

    a_we_needs_en: assert property (@(posedge clk_50MHz) disable iff (!rst)
        dmem_we |-> dmem_en);

endmodule

// File: design/fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module fetch_unit (
    input  logic                   clk_50MHz,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   branch_taken,
    input  logic [`CPU_DATA_W-1:0] branch_target,
    input  logic [`CPU_DATA_W-1:0] imem_inst,
    output logic [`CPU_DATA_W-1:0] imem_addr,
    output logic [`CPU_DATA_W-1:0] inst,
    output logic [`CPU_DATA_W-1:0] pc_next
);

    localparam logic [`CPU_DATA_W-1:0] NOP_WORD =
        {cpu_pkg::OPC_NOP, {(`CPU_DATA_W-5){1'b0}}};

    logic [`CPU_DATA_W-1:0] pc;
    logic [`CPU_DATA_W-1:0] pc_inc;

    assign pc_inc    = pc + 1'b1;
    assign imem_addr = pc;

    // branch wins over a stall
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            pc <= `CPU_RESET_PC;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (!stall) begin
            pc <= pc_inc;
        end
    end

    // fetch/decode register, flushed to a NOP
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            inst <= NOP_WORD;
        end else if (branch_taken) begin
            inst <= NOP_WORD;
        end else if (!stall) begin
            inst <= imem_inst;
        end
    end

    always_ff @(posedge clk_50MHz) begin
        if (!stall) begin
            pc_next <= pc_inc;
        end
    end

    a_branch_wins: assert property (@(posedge clk_50MHz) disable iff (!rst)
        branch_taken |=> (pc == $past(branch_target)) && (inst == NOP_WORD));

endmodule

// File: design/hazard_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module hazard_unit (
    input  logic                       clk_50MHz,
    input  logic                       rst,
    input  logic [`CPU_REG_ADDR_W-1:0] rd_addr_a,
    input  logic [`CPU_REG_ADDR_W-1:0] rd_addr_b,
    input  logic [`CPU_REG_ADDR_W-1:0] ex_dest,
    input  logic                       ex_reg_wr,
    input  logic                       ex_mem_en,
    input  logic                       ex_mem_we,
    input  logic [`CPU_REG_ADDR_W-1:0] ex_src_a,
    input  logic [`CPU_REG_ADDR_W-1:0] ex_src_b,
    input  logic [`CPU_REG_ADDR_W-1:0] mem_dest,
    input  logic                       mem_reg_wr,
    input  logic [`CPU_REG_ADDR_W-1:0] wb_dest,
    input  logic                       wb_reg_wr,
    output logic                       stall,
    output cpu_pkg::fwd_src_e          fwd_a,
    output cpu_pkg::fwd_src_e          fwd_b
);

    logic ex_is_load;

    // load result is not ready until writeback
    assign ex_is_load = ex_mem_en & ~ex_mem_we & ex_reg_wr;
    assign stall      = ex_is_load && (ex_dest == rd_addr_a || ex_dest == rd_addr_b);

    // newest result first
    assign fwd_a = (mem_reg_wr && mem_dest == ex_src_a) ? cpu_pkg::FWD_EX_MEM :
                   (wb_reg_wr && wb_dest == ex_src_a)   ? cpu_pkg::FWD_MEM_WB :
                                                          cpu_pkg::FWD_REG;
    assign fwd_b = (mem_reg_wr && mem_dest == ex_src_b) ? cpu_pkg::FWD_EX_MEM :
                   (wb_reg_wr && wb_dest == ex_src_b)   ? cpu_pkg::FWD_MEM_WB :
                                                          cpu_pkg::FWD_REG;

    // the inserted bubble clears the load from execute
    a_single_bubble: assert property (@(posedge clk_50MHz) disable iff (!rst)
        stall |=> !stall);

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module reg_file (
    input  logic                       clk_50MHz,
    input  logic                       rst,
    input  logic [`CPU_REG_ADDR_W-1:0] rd_addr_a,
    input  logic [`CPU_REG_ADDR_W-1:0] rd_addr_b,
    input  logic                       wr_en,
    input  logic [`CPU_REG_ADDR_W-1:0] wr_addr,
    input  logic [`CPU_DATA_W-1:0]     wr_data,
    output logic [`CPU_DATA_W-1:0]     rd_data_a,
    output logic [`CPU_DATA_W-1:0]     rd_data_b
);

    logic [`CPU_DATA_W-1:0] regs [0:(1<<`CPU_REG_ADDR_W)-1];

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < (1 << `CPU_REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // same-cycle write shows through to decode
    assign rd_data_a = (wr_en && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (wr_en && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

endmodule

// File: design/writeback_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module writeback_unit (
    input  logic                       clk_50MHz,
    input  logic                       rst,
    input  logic [`CPU_REG_ADDR_W-1:0] mem_dest,
    input  logic                       mem_reg_wr,
    input  cpu_pkg::wb_src_e           mem_wb_src,
    input  logic [`CPU_DATA_W-1:0]     mem_alu_result,
    input  logic [`CPU_DATA_W-1:0]     dmem_rdata,
    output logic                       wr_en,
    output logic [`CPU_REG_ADDR_W-1:0] wr_addr,
    output logic [`CPU_DATA_W-1:0]     wr_data
);

    cpu_pkg::wb_src_e       wb_src;
    logic [`CPU_DATA_W-1:0] alu_q;
    logic [`CPU_DATA_W-1:0] rdata_q;

    // memory/writeback register
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= mem_reg_wr;
        end
    end

    always_ff @(posedge clk_50MHz) begin
        wr_addr <= mem_dest;
        wb_src  <= mem_wb_src;
        alu_q   <= mem_alu_result;
        rdata_q <= dmem_rdata;
    end

    // also the forwarding value for execute
    assign wr_data = (wb_src == cpu_pkg::WB_MEM) ? rdata_q : alu_q;

endmodule

// File: include/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath widths
`define CPU_DATA_W      16
`define CPU_REG_ADDR_W  3

// instruction fields
`define CPU_OPC_HI      15
`define CPU_OPC_LO      11
`define CPU_RX_HI       10
`define CPU_RX_LO       8
`define CPU_RY_HI       7
`define CPU_RY_LO       5
`define CPU_RZ_HI       4
`define CPU_RZ_LO       2

// first fetch address
`define CPU_RESET_PC    16'h0000

`endif

// File: project.f
+incdir+include
design/cpu_pkg.sv
design/reg_file.sv
design/fetch_unit.sv
design/decode_unit.sv
design/hazard_unit.sv
design/execute_unit.sv
design/writeback_unit.sv
design/cpu_top.sv
tb/tb_cpu.sv

// File: tb/cpu_stim.txt
// program words, FFFFF, preload pairs (address value), FFFFF,
// expected stores in order (address data), FFFFF
6925    // 00 li    r1, 0x25
6AF0    // 01 li    r2, 0xf0
49FE    // 02 addiu r1, -2
E14D    // 03 addu  r3 = r1 + r2
D860    // 04 sw    r3, 0(r0)
E233    // 05 subu  r4 = r2 - r1
D881    // 06 sw    r4, 1(r0)
E157    // 07 subu  r5 = r1 - r2
0800    // 08 nop
D8A2    // 09 sw    r5, 2(r0)
EA8C    // 10 and   r2, r4
D843    // 11 sw    r2, 3(r0)
E98D    // 12 or    r1, r4
D824    // 13 sw    r1, 4(r0)
6E08    // 14 li    r6, 8
9EE0    // 15 lw    r7, 0(r6)
4F11    // 16 addiu r7, 0x11
D8E5    // 17 sw    r7, 5(r0)
9E61    // 18 lw    r3, 1(r6)
2302    // 19 beqz  r3, +2 taken
D86F    // 20 sw    skipped
D86E    // 21 sw    skipped
9E82    // 22 lw    r4, 2(r6)
D886    // 23 sw    r4, 6(r0)
2403    // 24 beqz  r4, +3 not taken
4C01    // 25 addiu r4, 1
D887    // 26 sw    r4, 7(r0)
1002    // 27 b     +2
D88D    // 28 sw    skipped
D88C    // 29 sw    skipped
6D5A    // 30 li    r5, 0x5a
D8AB    // 31 sw    r5, 11(r0)
17FF    // 32 b     -1, spin
FFFFF
0008 1234
0009 0000
000A 8001
FFFFF
0000 0113
0001 00CD
0002 FF33
0003 00C0
0004 00EF
0005 1245
0006 8001
0007 8002
000B 005A
FFFFF

// File: tb/tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_cpu;

    localparam int          STIM_DEPTH    = 128;
    localparam int          IMEM_DEPTH    = 64;
    localparam int          DMEM_DEPTH    = 256;
    localparam int          STORE_TIMEOUT = 400;
    localparam int          QUIET_CYCLES  = 40;
    localparam logic [19:0] MARKER        = 20'hFFFFF;

    logic                   clk_50MHz = 1'b0;
    logic                   rst;
    logic [`CPU_DATA_W-1:0] imem_addr;
    logic [`CPU_DATA_W-1:0] imem_inst;
    logic [`CPU_DATA_W-1:0] dmem_addr;
    logic [`CPU_DATA_W-1:0] dmem_wdata;
    logic                   dmem_en;
    logic                   dmem_we;
    logic [`CPU_DATA_W-1:0] dmem_rdata;

    // stim words are 20 bits wide, so the marker never looks like data
    logic [19:0]            stim [0:STIM_DEPTH-1];
    logic [`CPU_DATA_W-1:0] imem [0:IMEM_DEPTH-1];
    logic [`CPU_DATA_W-1:0] dmem [0:DMEM_DEPTH-1];
    logic [`CPU_DATA_W-1:0] exp_addr [$];
    logic [`CPU_DATA_W-1:0] exp_data [$];
    int                     store_count = 0;
    int                     errors = 0;
    int                     cycles;

    always #10 clk_50MHz = ~clk_50MHz;

    cpu_top DUT (
        .clk_50MHz (clk_50MHz),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_inst (imem_inst),
        .dmem_addr (dmem_addr),
        .dmem_wdata(dmem_wdata),
        .dmem_en   (dmem_en),
        .dmem_we   (dmem_we),
        .dmem_rdata(dmem_rdata)
    );

    // ******************************
    // memory models
    // ******************************
    assign imem_inst  = imem[imem_addr[$clog2(IMEM_DEPTH)-1:0]];
    assign dmem_rdata = dmem[dmem_addr[$clog2(DMEM_DEPTH)-1:0]];

    always @(posedge clk_50MHz) begin
        if (dmem_en && dmem_we) begin
            dmem[dmem_addr[$clog2(DMEM_DEPTH)-1:0]] <= dmem_wdata;
        end
    end

    // program, data preload and expected stores, split by markers
    task automatic load_stim();
        int pos;
        int prog_len;
        pos      = 0;
        prog_len = 0;
        for (int i = 0; i < STIM_DEPTH; i++) begin
            stim[i] = MARKER;
        end
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            dmem[i] = '0;
        end
        $readmemh("tb/cpu_stim.txt", stim);
        while (pos < STIM_DEPTH && prog_len < IMEM_DEPTH && stim[pos] != MARKER) begin
            imem[prog_len] = stim[pos][`CPU_DATA_W-1:0];
            prog_len++;
            pos++;
        end
        pos++;
        while (pos + 1 < STIM_DEPTH && stim[pos] != MARKER) begin
            dmem[stim[pos][$clog2(DMEM_DEPTH)-1:0]] = stim[pos + 1][`CPU_DATA_W-1:0];
            pos += 2;
        end
        pos++;
        while (pos + 1 < STIM_DEPTH && stim[pos] != MARKER) begin
            exp_addr.push_back(stim[pos][`CPU_DATA_W-1:0]);
            exp_data.push_back(stim[pos + 1][`CPU_DATA_W-1:0]);
            pos += 2;
        end
        assert (prog_len > 0 && exp_addr.size() > 0) else begin
            errors++;
            $display("stim file gave no program or no expected stores");
        end
    endtask

    // no memory traffic and PC at its reset value
    task automatic check_idle(input string phase);
        assert (dmem_en === 1'b0 && dmem_we === 1'b0 && imem_addr === `CPU_RESET_PC) else begin
            errors++;
            $display("FAIL t=%0t: outputs not idle %s, dmem_en=%b dmem_we=%b imem_addr=%h",
                     $time, phase, dmem_en, dmem_we, imem_addr);
        end
    endtask

    task automatic check_store(input logic [`CPU_DATA_W-1:0] addr,
                               input logic [`CPU_DATA_W-1:0] data);
        assert (store_count < exp_addr.size()) else begin
            errors++;
            $display("unexpected store of %h to address %h after the last expected one",
                     data, addr);
        end
        if (store_count < exp_addr.size()) begin
            assert (addr === exp_addr[store_count] && data === exp_data[store_count]) else begin
                errors++;
                $display("FAIL t=%0t: store %0d expected [%h]=%h, got [%h]=%h", $time,
                         store_count, exp_addr[store_count], exp_data[store_count], addr, data);
            end
        end
        store_count++;
    endtask

    // stores sampled mid-cycle, away from the clock edge
    always @(negedge clk_50MHz) begin
        if (rst === 1'b1 && dmem_en === 1'b1 && dmem_we === 1'b1) begin
            check_store(dmem_addr, dmem_wdata);
        end
    end

    // ******************************
    // main sequence
    // ******************************
    initial begin
        rst = 1'b0;
        load_stim();

        repeat (2) begin
            @(negedge clk_50MHz);
            check_idle("during reset");
        end
        @(posedge clk_50MHz);
        #1 rst = 1'b1;
        @(negedge clk_50MHz);
        check_idle("after reset");

        // all expected stores, bounded
        cycles = 0;
        while (store_count < exp_addr.size() && cycles < STORE_TIMEOUT) begin
            @(posedge clk_50MHz);
            cycles++;
        end
        assert (store_count >= exp_addr.size()) else begin
            errors++;
            $display("timeout: only %0d of %0d expected stores seen after %0d cycles",
                     store_count, exp_addr.size(), cycles);
        end

        // program spins on its last branch, the monitor flags any store
        cycles = 0;
        while (cycles < QUIET_CYCLES) begin
            @(posedge clk_50MHz);
            cycles++;
        end

        $display("%0d of %0d expected stores seen, %0d errors",
                 store_count, exp_addr.size(), errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
